// File: cache_geom_pkg.sv
/*
 * Instruction cache geometry
 * Address split, line and instruction widths, age counter default
 */
`default_nettype none

package cache_geom_pkg;

    localparam int ADDR_W    = 64;
    localparam int IDX_LSB   = 3;                     // Byte offset within the 8-byte line
    localparam int TAG_LSB   = 9;
    localparam int IDX_W     = TAG_LSB - IDX_LSB;
    localparam int TAG_W     = ADDR_W - TAG_LSB;
    localparam int NUM_SETS  = 1 << IDX_W;
    localparam int HALF_BIT  = 2;                     // Upper or lower instruction

    localparam int AGE_W_DEF = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [IDX_W-1:0]  index_t;
    typedef logic [63:0]       line_t;
    typedef logic [31:0]       inst_t;
    typedef logic [0:0]        way_sel_t;

endpackage

`default_nettype wire

// File: cache_bus_pkg.sv
/*
 * Instruction cache port bundles
 * Fetch request and response, refill request and response
 */
`default_nettype none

package cache_bus_pkg;

    // From the fetch stage
    typedef struct packed {
        logic                  valid;
        cache_geom_pkg::addr_t addr;
    } fetch_req_t;

    // Back to the fetch stage, one-cycle pulse
    typedef struct packed {
        logic                  valid;
        cache_geom_pkg::inst_t inst;
    } fetch_rsp_t;

    // Level request, held until the line returns
    typedef struct packed {
        logic                  valid;
        cache_geom_pkg::addr_t addr;   // Line aligned
    } refill_req_t;

    // Line strobe from memory
    typedef struct packed {
        logic                  valid;
        cache_geom_pkg::line_t line;
    } refill_rsp_t;

endpackage

`default_nettype wire

// File: icache_way.sv
/*
 * One cache way: tag, valid bit and line per set
 * Registered read, a write sets the entry valid
 */
`default_nettype none

module icache_way (
    input  wire                             clk,
    input  wire                             i_rst,
    input  wire  cache_geom_pkg::index_t    i_index,
    input  wire                             i_wr_en,
    input  wire  cache_geom_pkg::tag_t      i_wr_tag,
    input  wire  cache_geom_pkg::line_t     i_wr_line,
    output cache_geom_pkg::tag_t            o_tag,
    output logic                            o_vld,
    output cache_geom_pkg::line_t           o_line
);
    import cache_geom_pkg::*;

    tag_t                tag_mem  [NUM_SETS];
    line_t               line_mem [NUM_SETS];
    logic [NUM_SETS-1:0] vld_q;

    // Valid bits
    always_ff @(posedge clk) begin
        if (i_rst) begin
            vld_q <= '0;
            o_vld <= 1'b0;
        end else begin
            if (i_wr_en) begin
                vld_q[i_index] <= 1'b1;
            end
            o_vld <= vld_q[i_index];      // Old value on a same-cycle write
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            tag_mem[i_index]  <= i_wr_tag;
            line_mem[i_index] <= i_wr_line;
        end
        o_tag  <= tag_mem[i_index];
        o_line <= line_mem[i_index];
    end

endmodule

`default_nettype wire

// File: icache_age.sv
/*
 * Saturating age counters per set and way, victim selection
 */
`default_nettype none

module icache_age #(
    parameter int AGE_W = cache_geom_pkg::AGE_W_DEF
) (
    input  wire                             clk,
    input  wire                             i_rst,
    input  wire  cache_geom_pkg::index_t    i_index,
    input  wire                             i_accept,
    input  wire                             i_hit_stb,
    input  wire  cache_geom_pkg::way_sel_t  i_hit_way,
    input  wire                             i_fill_stb,
    input  wire  cache_geom_pkg::way_sel_t  i_fill_way,
    input  wire                             i_vld0,
    input  wire                             i_vld1,
    output cache_geom_pkg::way_sel_t        o_victim
);
    import cache_geom_pkg::*;

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    logic [AGE_W-1:0] age_q [2][NUM_SETS];
    logic [1:0]       clr;
    logic [AGE_W-1:0] cur0;
    logic [AGE_W-1:0] cur1;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            clr[w] = (i_hit_stb && i_hit_way == way_sel_t'(w)) ||
                     (i_fill_stb && i_fill_way == way_sel_t'(w));
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    age_q[w][s] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    if (clr[w] && i_index == index_t'(s)) begin
                        age_q[w][s] <= '0;                    // Touched way wins
                    end else if (i_accept && age_q[w][s] != AGE_MAX) begin
                        age_q[w][s] <= age_q[w][s] + 1'b1;
                    end
                end
            end
        end
    end

    assign cur0 = age_q[0][i_index];
    assign cur1 = age_q[1][i_index];

    // Empty way first, then the older one, way 0 on a tie
    always_comb begin
        if (!i_vld0) begin
            o_victim = 1'b0;
        end else if (!i_vld1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = (cur1 > cur0) ? 1'b1 : 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: icache_ctrl.sv
/*
 * Instruction cache control FSM
 * Lookup, hit compare, refill request and line fill, instruction select
 */
`default_nettype none

module icache_ctrl (
    input  wire                                 clk,
    input  wire                                 i_rst,
    input  wire  cache_bus_pkg::fetch_req_t     i_fetch,
    output logic                                o_ready,
    output cache_bus_pkg::fetch_rsp_t           o_rsp,
    output cache_bus_pkg::refill_req_t          o_refill,
    input  wire  cache_bus_pkg::refill_rsp_t    i_refill,
    output cache_geom_pkg::index_t              o_index,
    output cache_geom_pkg::tag_t                o_wr_tag,
    output cache_geom_pkg::line_t               o_wr_line,
    output logic                                o_wr_en0,
    output logic                                o_wr_en1,
    input  wire  cache_geom_pkg::tag_t          i_tag0,
    input  wire  cache_geom_pkg::tag_t          i_tag1,
    input  wire                                 i_vld0,
    input  wire                                 i_vld1,
    input  wire  cache_geom_pkg::line_t         i_line0,
    input  wire  cache_geom_pkg::line_t         i_line1,
    output cache_geom_pkg::way_sel_t            o_hit_way,
    output logic                                o_hit_stb,
    output logic                                o_fill_stb,
    output logic                                o_accept,
    input  wire  cache_geom_pkg::way_sel_t      i_victim
);
    import cache_geom_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        CHECK,
        REFILL,
        FILL_WAIT
    } state_t;

    state_t state_q;
    state_t state_d;

    addr_t  addr_q;
    tag_t   tag_cur;
    logic   hit0;
    logic   hit1;
    logic   hit;
    logic   miss;
    logic   fill;
    line_t  hit_line;
    inst_t  inst_sel;

    logic   rsp_vld_q;
    inst_t  rsp_inst_q;
    logic   refill_vld_q;
    addr_t  refill_addr_q;

    assign o_ready  = (state_q == IDLE) && !rsp_vld_q;   // Low during the response cycle
    assign o_accept = i_fetch.valid && o_ready;

    assign tag_cur  = addr_q[ADDR_W-1:TAG_LSB];
    assign o_index  = addr_q[TAG_LSB-1:IDX_LSB];

    // Hit compare on the way outputs
    assign hit0 = i_vld0 && (i_tag0 == tag_cur);
    assign hit1 = i_vld1 && (i_tag1 == tag_cur);
    assign hit  = (state_q == CHECK) && (hit0 || hit1);
    assign miss = (state_q == CHECK) && !(hit0 || hit1);

    assign o_hit_stb = hit;
    assign o_hit_way = hit0 ? 1'b0 : 1'b1;

    assign hit_line = hit0 ? i_line0 : i_line1;
    assign inst_sel = addr_q[HALF_BIT] ? hit_line[63:32] : hit_line[31:0];

    // Fill on the refill strobe edge
    assign fill       = (state_q == REFILL) && i_refill.valid;
    assign o_fill_stb = fill;
    assign o_wr_en0   = fill && (i_victim == 1'b0);
    assign o_wr_en1   = fill && (i_victim == 1'b1);
    assign o_wr_tag   = tag_cur;
    assign o_wr_line  = i_refill.line;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (o_accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = CHECK;              // Way read in flight
            end
            CHECK: begin
                state_d = hit ? IDLE : REFILL;
            end
            REFILL: begin
                if (i_refill.valid) begin
                    state_d = FILL_WAIT;
                end
            end
            FILL_WAIT: begin
                state_d = LOOKUP;             // Let the write land before re-reading
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q      <= IDLE;
            rsp_vld_q    <= 1'b0;
            refill_vld_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            rsp_vld_q <= hit;
            if (miss) begin
                refill_vld_q <= 1'b1;
            end else if (fill) begin
                refill_vld_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_accept) begin
            addr_q <= i_fetch.addr;
        end
        if (hit) begin
            rsp_inst_q <= inst_sel;
        end
        if (miss) begin
            refill_addr_q <= {addr_q[ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
        end
    end

    assign o_rsp.valid    = rsp_vld_q;
    assign o_rsp.inst     = rsp_inst_q;
    assign o_refill.valid = refill_vld_q;
    assign o_refill.addr  = refill_addr_q;

endmodule

`default_nettype wire

// File: icache_top.sv
/*
 * Two-way set-associative instruction cache
 */
`default_nettype none

module icache_top #(
    parameter int AGE_W = cache_geom_pkg::AGE_W_DEF
) (
    input  wire                                 clk,
    input  wire                                 i_rst,
    input  wire  cache_bus_pkg::fetch_req_t     i_fetch,
    output logic                                o_ready,
    output cache_bus_pkg::fetch_rsp_t           o_rsp,
    output cache_bus_pkg::refill_req_t          o_refill,
    input  wire  cache_bus_pkg::refill_rsp_t    i_refill
);
    import cache_geom_pkg::*;

    index_t   index;
    tag_t     wr_tag;
    line_t    wr_line;
    logic     wr_en0;
    logic     wr_en1;
    tag_t     tag0;
    tag_t     tag1;
    logic     vld0;
    logic     vld1;
    line_t    line0;
    line_t    line1;
    way_sel_t hit_way;
    logic     hit_stb;
    logic     fill_stb;
    logic     accept;
    way_sel_t victim;

    icache_ctrl ctrl0 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_fetch    (i_fetch),
        .o_ready    (o_ready),
        .o_rsp      (o_rsp),
        .o_refill   (o_refill),
        .i_refill   (i_refill),
        .o_index    (index),
        .o_wr_tag   (wr_tag),
        .o_wr_line  (wr_line),
        .o_wr_en0   (wr_en0),
        .o_wr_en1   (wr_en1),
        .i_tag0     (tag0),
        .i_tag1     (tag1),
        .i_vld0     (vld0),
        .i_vld1     (vld1),
        .i_line0    (line0),
        .i_line1    (line1),
        .o_hit_way  (hit_way),
        .o_hit_stb  (hit_stb),
        .o_fill_stb (fill_stb),
        .o_accept   (accept),
        .i_victim   (victim)
    );

    icache_way way0 (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_index   (index),
        .i_wr_en   (wr_en0),
        .i_wr_tag  (wr_tag),
        .i_wr_line (wr_line),
        .o_tag     (tag0),
        .o_vld     (vld0),
        .o_line    (line0)
    );

    icache_way way1 (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_index   (index),
        .i_wr_en   (wr_en1),
        .i_wr_tag  (wr_tag),
        .i_wr_line (wr_line),
        .o_tag     (tag1),
        .o_vld     (vld1),
        .o_line    (line1)
    );

    // Fill way is the victim picked for the same index
    icache_age #(
        .AGE_W (AGE_W)
    ) age0 (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_index    (index),
        .i_accept   (accept),
        .i_hit_stb  (hit_stb),
        .i_hit_way  (hit_way),
        .i_fill_stb (fill_stb),
        .i_fill_way (victim),
        .i_vld0     (vld0),
        .i_vld1     (vld1),
        .o_victim   (victim)
    );

endmodule

`default_nettype wire

// File: tb_icache.sv
/*
 * Testbench for the two-way instruction cache
 * Random fetches checked against a memory model and a reference cache model
 */
`default_nettype none

module tb_icache;
    timeunit 1ns;
    timeprecision 1ps;

    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int AGE_W     = 3;
    localparam int AGE_MAX   = (1 << AGE_W) - 1;
    localparam int NUM_FETCH = 400;
    localparam int CYC_LIMIT = NUM_FETCH * 20;

    logic        clk;
    logic        rst;
    fetch_req_t  fetch_req;
    logic        ready;
    fetch_rsp_t  fetch_rsp;
    refill_req_t refill_req;
    refill_rsp_t refill_rsp;

    int unsigned cyc;
    logic [31:0] rnd_state;
    tag_t        tag_pool [4];
    index_t      set_pool [8];

    // Reference cache state
    logic        m_vld [2][64];
    tag_t        m_tag [2][64];
    int          m_age [2][64];

    icache_top #(
        .AGE_W (AGE_W)
    ) dut0 (
        .clk      (clk),
        .i_rst    (rst),
        .i_fetch  (fetch_req),
        .o_ready  (ready),
        .o_rsp    (fetch_rsp),
        .o_refill (refill_req),
        .i_refill (refill_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(negedge clk) begin
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYC_LIMIT);
            end_with_failure();
        end
    end

    task automatic end_with_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rnd_state = lcg_next(rnd_state);
        r = rnd_state;
    endtask

    // Memory contents, a fixed hash of the line address
    function automatic line_t mem_line(input addr_t line_addr);
        logic [63:0] h;
        h = line_addr * 64'h9e3779b97f4a7c15;
        return h ^ (h >> 31) ^ {line_addr[31:0], line_addr[63:32]};
    endfunction

    // Reference lookup, returns whether the fetch misses
    task automatic model_fetch(input addr_t a, output logic miss);
        index_t idx;
        tag_t   tg;
        int     v;

        idx = a[8:3];
        tg  = a[63:9];
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 64; s++) begin
                if (m_age[w][s] < AGE_MAX) begin
                    m_age[w][s]++;
                end
            end
        end
        if (m_vld[0][idx] && m_tag[0][idx] == tg) begin
            miss         = 1'b0;
            m_age[0][idx] = 0;
        end else if (m_vld[1][idx] && m_tag[1][idx] == tg) begin
            miss          = 1'b0;
            m_age[1][idx] = 0;
        end else begin
            miss = 1'b1;
            if (!m_vld[0][idx]) begin
                v = 0;
            end else if (!m_vld[1][idx]) begin
                v = 1;
            end else begin
                v = (m_age[1][idx] > m_age[0][idx]) ? 1 : 0;   // Way 0 on a tie
            end
            m_vld[v][idx] = 1'b1;
            m_tag[v][idx] = tg;
            m_age[v][idx] = 0;
        end
    endtask

    task automatic run_fetch(input addr_t a, output logic miss);
        logic        exp_miss;
        logic [31:0] r;
        line_t       exp_line;
        inst_t       exp_inst;
        addr_t       line_addr;
        int unsigned acc_cyc;
        int unsigned fill_cyc;
        int          delay;

        model_fetch(a, exp_miss);
        line_addr = {a[63:3], 3'b000};
        exp_line  = mem_line(line_addr);
        exp_inst  = a[2] ? exp_line[63:32] : exp_line[31:0];

        do begin
            @(negedge clk);
        end while (!ready);
        @(posedge clk);
        fetch_req.valid <= 1'b1;
        fetch_req.addr  <= a;
        @(posedge clk);                                 // Accepting edge
        fetch_req.valid <= 1'b0;
        @(negedge clk);
        acc_cyc = cyc;
        check_value("ready low while busy", 64'd0, 64'(ready));

        do begin
            @(negedge clk);
        end while (!fetch_rsp.valid && !refill_req.valid);
        miss = refill_req.valid;
        check_value("miss prediction", 64'(exp_miss), 64'(miss));

        if (miss) begin
            check_value("refill latency", 64'(acc_cyc + 2), 64'(cyc));
            check_value("no response before fill", 64'd0, 64'(fetch_rsp.valid));
            check_value("refill address", line_addr, refill_req.addr);
            draw_random(r);
            delay = int'(r[23:16]) % 6;
            repeat (delay) begin
                @(negedge clk);
                check_value("refill valid held", 64'd1, 64'(refill_req.valid));
                check_value("refill address held", line_addr, refill_req.addr);
            end
            @(posedge clk);
            refill_rsp.valid <= 1'b1;
            refill_rsp.line  <= mem_line(line_addr);
            @(negedge clk);
            check_value("refill valid held", 64'd1, 64'(refill_req.valid));
            check_value("refill address held", line_addr, refill_req.addr);
            @(posedge clk);                             // Fill edge
            refill_rsp.valid <= 1'b0;
            @(negedge clk);
            fill_cyc = cyc;
            check_value("refill low after pulse", 64'd0, 64'(refill_req.valid));
            do begin
                @(negedge clk);
                check_value("no second refill", 64'd0, 64'(refill_req.valid));
            end while (!fetch_rsp.valid);
            check_value("response after fill", 64'(fill_cyc + 3), 64'(cyc));
        end else begin
            check_value("hit latency", 64'(acc_cyc + 2), 64'(cyc));
        end
        check_value("instruction", 64'(exp_inst), 64'(fetch_rsp.inst));

        @(negedge clk);
        check_value("response pulse width", 64'd0, 64'(fetch_rsp.valid));
        check_value("ready after response", 64'd1, 64'(ready));
        check_value("no refill after response", 64'd0, 64'(refill_req.valid));
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        addr_t       a;
        logic        miss;
        int          misses;

        rst        <= 1'b1;
        fetch_req  <= '0;
        refill_rsp <= '0;
        rnd_state  = 32'h30b331bb;
        misses     = 0;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 64; s++) begin
                m_vld[w][s] = 1'b0;
                m_tag[w][s] = '0;
                m_age[w][s] = 0;
            end
        end
        // Few tags and sets so that lines compete for the two ways
        for (int i = 0; i < 4; i++) begin
            draw_random(r);
            draw_random(r2);
            tag_pool[i] = {r[22:0], r2};
        end
        for (int i = 0; i < 8; i++) begin
            draw_random(r);
            set_pool[i] = r[21:16];
        end

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("ready after reset", 64'd1, 64'(ready));
        check_value("response after reset", 64'd0, 64'(fetch_rsp.valid));
        check_value("refill after reset", 64'd0, 64'(refill_req.valid));

        for (int n = 0; n < NUM_FETCH; n++) begin
            draw_random(r);
            a = {tag_pool[r[17:16]], set_pool[r[20:18]], r[21], 2'b00};
            run_fetch(a, miss);
            if (miss) begin
                misses++;
            end
        end

        $display("%0d fetches, %0d misses", NUM_FETCH, misses);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
cache_geom_pkg.sv
cache_bus_pkg.sv
icache_way.sv
icache_age.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_icache -f build.f -o sim_icache

./obj_dir/sim_icache | tee sim.log

grep -q "Testbench passed" sim.log
